// File: verilog.f
axi_rd_pkg.sv
demux_ctrl_pkg.sv
id_slot.sv
ar_route.sv
r_merge.sv
rd_demux_top.sv
rd_demux_checker.sv
tb_rd_demux.sv

// File: tb_rd_demux.sv
`default_nettype none
`timescale 1ns/1ps

module tb_rd_demux;

  localparam int unsigned NUM_PORTS     = 3;
  localparam int unsigned MAX_TRANS     = 4;
  localparam int unsigned NUM_AR        = 2000;
  localparam int unsigned AR_TIMEOUT    = 1000;
  localparam int unsigned DRAIN_TIMEOUT = 5000;

  logic                                        clk_i = 1'b0;
  logic                                        rst_i;
  logic                                        ar_valid;
  axi_rd_pkg::ar_chan_t                        ar;
  demux_ctrl_pkg::port_sel_t                   ar_sel;
  logic                                        ar_ready;
  logic                                        r_valid;
  axi_rd_pkg::r_chan_t                         r;
  logic                                        r_ready;
  logic [NUM_PORTS-1:0]                        mst_ar_valid;
  axi_rd_pkg::ar_chan_t [NUM_PORTS-1:0]        mst_ar;
  logic [NUM_PORTS-1:0]                        mst_ar_ready;
  logic [NUM_PORTS-1:0]                        mst_r_valid;
  axi_rd_pkg::r_chan_t [NUM_PORTS-1:0]         mst_r;
  logic [NUM_PORTS-1:0]                        mst_r_ready;

  // random source
  logic [31:0]                 lfsr_q = 32'h4745d4aa;
  // upstream AR generator
  logic                        ar_pend;
  axi_rd_pkg::ar_chan_t        ar_next;
  demux_ctrl_pkg::port_sel_t   sel_next;
  int unsigned                 ar_issued;
  int unsigned                 ar_done;
  logic                        ar_xfer;
  // downstream port models
  axi_rd_pkg::ar_chan_t        port_q[NUM_PORTS][$];
  int unsigned                 beat_idx[NUM_PORTS];
  logic                        port_hold[NUM_PORTS];
  // reference model
  int unsigned                 m_cnt[demux_ctrl_pkg::NUM_SLOTS];
  demux_ctrl_pkg::port_sel_t   m_sel[demux_ctrl_pkg::NUM_SLOTS];
  axi_rd_pkg::r_chan_t         exp_q[NUM_PORTS][$];
  demux_ctrl_pkg::port_sel_t   arb_ptr;
  logic                        arb_lock;

  rd_demux_top #(
    .NUM_PORTS (NUM_PORTS),
    .MAX_TRANS (MAX_TRANS)
  ) i_dut (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .ar_valid_i     (ar_valid),
    .ar_i           (ar),
    .ar_sel_i       (ar_sel),
    .ar_ready_o     (ar_ready),
    .r_valid_o      (r_valid),
    .r_o            (r),
    .r_ready_i      (r_ready),
    .mst_ar_valid_o (mst_ar_valid),
    .mst_ar_o       (mst_ar),
    .mst_ar_ready_i (mst_ar_ready),
    .mst_r_valid_i  (mst_r_valid),
    .mst_r_i        (mst_r),
    .mst_r_ready_o  (mst_r_ready)
  );

  always #2 clk_i = ~clk_i;

  // ------------------------------
  // random numbers and helpers
  // ------------------------------

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // beat b of a burst: addr plus beat number, last on beat len
  function automatic axi_rd_pkg::r_chan_t make_beat(input axi_rd_pkg::ar_chan_t a,
                                                    input int unsigned b);
    axi_rd_pkg::r_chan_t beat;
    beat.id   = a.id;
    beat.data = a.addr + axi_rd_pkg::data_t'(b);
    beat.resp = axi_rd_pkg::RESP_OKAY;
    beat.last = (axi_rd_pkg::len_t'(b) == a.len);
    return beat;
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_ar(input string name, input axi_rd_pkg::ar_chan_t exp_v,
                            input axi_rd_pkg::ar_chan_t act_v);
    if (act_v !== exp_v) begin
      $display("MISMATCH %s expected %h actual %h", name, exp_v, act_v);
      fail_now("wrong AR word");
    end
  endtask

  task automatic compare_r(input string name, input axi_rd_pkg::r_chan_t exp_v,
                           input axi_rd_pkg::r_chan_t act_v);
    if (act_v !== exp_v) begin
      $display("MISMATCH %s expected %h actual %h", name, exp_v, act_v);
      fail_now("wrong R beat");
    end
  endtask

  task automatic compare_sel(input string name, input demux_ctrl_pkg::port_sel_t exp_v,
                             input demux_ctrl_pkg::port_sel_t act_v);
    if (act_v !== exp_v) begin
      $display("MISMATCH %s expected %0d actual %0d", name, exp_v, act_v);
      fail_now("wrong port granted");
    end
  endtask

  task automatic compare_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("MISMATCH %s expected %b actual %b", name, exp_v, act_v);
      fail_now("wrong handshake signal");
    end
  endtask

  // ------------------------------
  // mid-cycle checks and model update
  // ------------------------------
  task automatic check_cycle();
    demux_ctrl_pkg::look_id_t  slot;
    logic                      blocked;
    logic                      exp_fwd;
    logic                      found;
    demux_ctrl_pkg::port_sel_t gnt;
    demux_ctrl_pkg::port_sel_t act_gnt;
    axi_rd_pkg::r_chan_t       beat;
    axi_rd_pkg::ar_chan_t      head;
    int unsigned               cand;
    if (i_dut.i_checker.err_count != 0) begin
      fail_now("a checker assertion failed");
    end
    // AR stall rule: any full slot, or same id live on another port
    slot    = ar.id[demux_ctrl_pkg::LOOK_BITS-1:0];
    blocked = 1'b0;
    for (int unsigned s = 0; s < demux_ctrl_pkg::NUM_SLOTS; s++) begin
      if (m_cnt[s] == MAX_TRANS - 1) blocked = 1'b1;
    end
    if (m_cnt[slot] != 0 && m_sel[slot] != ar_sel) blocked = 1'b1;
    exp_fwd = ar_valid && !blocked;
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      compare_bit($sformatf("ar_valid port %0d", p), exp_fwd && (ar_sel == p),
                  mst_ar_valid[p]);
    end
    if (exp_fwd) compare_ar("ar_word", ar, mst_ar[ar_sel]);
    compare_bit("ar_ready", exp_fwd && mst_ar_ready[ar_sel], ar_ready);
    ar_xfer = ar_valid && ar_ready;

    // R arbiter model, held grant or first valid from the pointer
    compare_bit("r_valid", |mst_r_valid, r_valid);
    gnt   = arb_ptr;
    found = arb_lock;
    for (int off = 0; off < NUM_PORTS; off++) begin
      cand = (arb_ptr + off) % NUM_PORTS;
      if (!found && mst_r_valid[cand]) begin
        gnt   = demux_ctrl_pkg::port_sel_t'(cand);
        found = 1'b1;
      end
    end
    found = found && mst_r_valid[gnt];
    // port that the DUT hands upstream ready to
    act_gnt = '0;
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      if (mst_r_ready[p]) act_gnt = demux_ctrl_pkg::port_sel_t'(p);
    end
    if (found && r_ready) compare_sel("r_grant", gnt, act_gnt);
    if (found) begin
      if (exp_q[gnt].size() == 0) fail_now("R beat from a port with no burst pending");
      compare_r("r_beat", exp_q[gnt][0], r);
    end
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      compare_bit($sformatf("r_ready port %0d", p), r_ready && found && (gnt == p),
                  mst_r_ready[p]);
    end
    if (found && r_ready) begin
      beat = exp_q[gnt].pop_front();
      if (beat.last) m_cnt[beat.id[demux_ctrl_pkg::LOOK_BITS-1:0]]--;
      arb_ptr  = (gnt == NUM_PORTS - 1) ? '0 : gnt + 1'b1;
      arb_lock = 1'b0;
    end else if (found) begin
      arb_ptr  = gnt;
      arb_lock = 1'b1;
    end

    // accepted AR: record it and queue its expected beats
    if (ar_xfer) begin
      m_cnt[slot]++;
      m_sel[slot] = ar_sel;
      for (int unsigned b = 0; b <= ar.len; b++) exp_q[ar_sel].push_back(make_beat(ar, b));
      ar_pend = 1'b0;
      ar_done++;
    end

    // port models take ARs and retire beats
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      if (mst_ar_valid[p] && mst_ar_ready[p]) port_q[p].push_back(mst_ar[p]);
      if (mst_r_valid[p] && mst_r_ready[p]) begin
        port_hold[p] = 1'b0;
        head         = port_q[p][0];
        if (beat_idx[p] == head.len) begin
          void'(port_q[p].pop_front());
          beat_idx[p] = 0;
        end else begin
          beat_idx[p]++;
        end
      end
    end
  endtask

  // ------------------------------
  // stimulus on the rising edge
  // ------------------------------
  task automatic drive_inputs();
    axi_rd_pkg::ar_chan_t a;
    logic [31:0]          v;
    // new AR only once the previous one has gone
    if (!ar_pend && ar_issued < NUM_AR && rand_bits(1) == 1) begin
      a.id   = axi_rd_pkg::id_t'(rand_bits(4));
      a.addr = rand_bits(32);
      a.len  = axi_rd_pkg::len_t'(rand_bits(2));
      v      = rand_bits(2);
      if (v >= NUM_PORTS) v = v - NUM_PORTS;
      ar_next  = a;
      sel_next = demux_ctrl_pkg::port_sel_t'(v);
      ar_pend  = 1'b1;
      ar_issued++;
    end
    ar_valid <= ar_pend;
    ar       <= ar_next;
    ar_sel   <= sel_next;
    // upstream ready about three cycles in four
    v = rand_bits(2);
    r_ready <= |v[1:0];
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      v = rand_bits(1);
      mst_ar_ready[p] <= v[0];
      // random gap before each beat, then held until taken
      if (!port_hold[p] && port_q[p].size() != 0) begin
        v = rand_bits(1);
        port_hold[p] = v[0];
      end
      if (port_q[p].size() != 0) mst_r[p] <= make_beat(port_q[p][0], beat_idx[p]);
      mst_r_valid[p] <= port_hold[p];
    end
  endtask

  task automatic run_cycle();
    @(negedge clk_i);
    check_cycle();
    @(posedge clk_i);
    drive_inputs();
  endtask

  initial begin
    int unsigned idle;
    int unsigned pending;
    rst_i        = 1'b1;
    ar_valid     = 1'b0;
    ar           = '0;
    ar_sel       = '0;
    r_ready      = 1'b0;
    mst_ar_ready = '0;
    mst_r_valid  = '0;
    mst_r        = '0;
    ar_pend      = 1'b0;
    ar_next      = '0;
    sel_next     = '0;
    ar_issued    = 0;
    ar_done      = 0;
    arb_ptr      = '0;
    arb_lock     = 1'b0;
    for (int unsigned s = 0; s < demux_ctrl_pkg::NUM_SLOTS; s++) begin
      m_cnt[s] = 0;
      m_sel[s] = '0;
    end
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      beat_idx[p]  = 0;
      port_hold[p] = 1'b0;
    end
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    // traffic phase, each AR must get through within the timeout
    idle = 0;
    while (ar_done < NUM_AR) begin
      run_cycle();
      idle = ar_xfer ? 0 : idle + 1;
      if (idle > AR_TIMEOUT) fail_now("timeout: no AR transfer for too many cycles");
    end

    // drain phase, wait for every burst to come back
    idle    = 0;
    pending = 1;
    while (pending != 0) begin
      run_cycle();
      pending = 0;
      for (int unsigned p = 0; p < NUM_PORTS; p++) pending += exp_q[p].size();
      idle++;
      if (idle > DRAIN_TIMEOUT) fail_now("timeout: read bursts still outstanding");
    end

    // let the assertions of the last edge settle
    @(negedge clk_i);
    if (i_dut.i_checker.err_count != 0) begin
      fail_now("a checker assertion failed");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: rd_demux_checker.sv
`default_nettype none
`timescale 1ns/1ps

// handshake properties of the read demux, bound into rd_demux_top
module rd_demux_checker #(
  parameter int unsigned NUM_PORTS = 3
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_i,
  input  wire logic                 ar_valid_i,
  input  wire logic                 ar_ready_i,
  input  wire logic [NUM_PORTS-1:0] mst_ar_valid_i,
  input  wire logic [NUM_PORTS-1:0] mst_ar_ready_i,
  input  wire logic [NUM_PORTS-1:0] mst_r_ready_i
);

  // failed assertions so far, read by the testbench
  int unsigned err_count = 0;

  // ------------------------------
  // one-hot routing
  // ------------------------------
  a_ar_onehot : assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(mst_ar_valid_i))
    else begin
      $error("more than one downstream AR valid at a time");
      err_count++;
    end

  a_r_onehot : assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(mst_r_ready_i))
    else begin
      $error("more than one downstream R ready at a time");
      err_count++;
    end

  // ------------------------------
  // AR handshake rules
  // ------------------------------

  // a waiting forwarded AR never retracts its valid
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_hold
    a_ar_hold : assert property (@(posedge clk_i) disable iff (rst_i)
      mst_ar_valid_i[p] && !mst_ar_ready_i[p] |=> mst_ar_valid_i[p])
      else begin
        $error("downstream AR valid dropped without a transfer");
        err_count++;
      end
  end

  a_ready_needs_valid : assert property (@(posedge clk_i) disable iff (rst_i)
    ar_ready_i |-> ar_valid_i)
    else begin
      $error("upstream AR ready without AR valid");
      err_count++;
    end

endmodule

bind rd_demux_top rd_demux_checker #(
  .NUM_PORTS (NUM_PORTS)
) i_checker (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .ar_valid_i     (ar_valid_i),
  .ar_ready_i     (ar_ready_o),
  .mst_ar_valid_i (mst_ar_valid_o),
  .mst_ar_ready_i (mst_ar_ready_i),
  .mst_r_ready_i  (mst_r_ready_o)
);

`default_nettype wire

// File: rd_demux_top.sv
`default_nettype none
`timescale 1ns/1ps

// read-only AXI demux, one upstream port to NUM_PORTS downstream ports
module rd_demux_top #(
  parameter int unsigned NUM_PORTS = 3,
  parameter int unsigned MAX_TRANS = 4
) (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_i,
  // upstream AR
  input  wire logic                                    ar_valid_i,
  input  wire axi_rd_pkg::ar_chan_t                    ar_i,
  input  wire demux_ctrl_pkg::port_sel_t               ar_sel_i,
  output      logic                                    ar_ready_o,
  // upstream R
  output      logic                                    r_valid_o,
  output      axi_rd_pkg::r_chan_t                     r_o,
  input  wire logic                                    r_ready_i,
  // downstream AR
  output      logic [NUM_PORTS-1:0]                    mst_ar_valid_o,
  output      axi_rd_pkg::ar_chan_t [NUM_PORTS-1:0]    mst_ar_o,
  input  wire logic [NUM_PORTS-1:0]                    mst_ar_ready_i,
  // downstream R
  input  wire logic [NUM_PORTS-1:0]                    mst_r_valid_i,
  input  wire axi_rd_pkg::r_chan_t [NUM_PORTS-1:0]     mst_r_i,
  output      logic [NUM_PORTS-1:0]                    mst_r_ready_o
);

  // port count must fit the select field
  if (NUM_PORTS < 2 || NUM_PORTS > demux_ctrl_pkg::MAX_PORTS) begin : gen_bad_ports
    $error("rd_demux_top NUM_PORTS out of range");
  end

  // state of every ordering slot, seen by the router
  demux_ctrl_pkg::slot_status_t [demux_ctrl_pkg::NUM_SLOTS-1:0] slot_status;

  // slot updates
  logic                      push;
  demux_ctrl_pkg::look_id_t  push_slot;
  demux_ctrl_pkg::port_sel_t push_sel;
  logic                      pop;
  demux_ctrl_pkg::look_id_t  pop_slot;

  // ------------------------------
  // AR path
  // ------------------------------
  ar_route #(
    .NUM_PORTS (NUM_PORTS)
  ) i_ar_route (
    .ar_valid_i     (ar_valid_i),
    .ar_i           (ar_i),
    .ar_sel_i       (ar_sel_i),
    .mst_ar_ready_i (mst_ar_ready_i),
    .slot_status_i  (slot_status),
    .ar_ready_o     (ar_ready_o),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_o       (mst_ar_o),
    .push_o         (push),
    .push_slot_o    (push_slot),
    .push_sel_o     (push_sel)
  );

  // one outstanding-burst counter per low id value
  for (genvar i = 0; i < demux_ctrl_pkg::NUM_SLOTS; i++) begin : gen_slots
    id_slot #(
      .MAX_TRANS (MAX_TRANS),
      .SLOT_IDX  (i)
    ) i_id_slot (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .push_i      (push),
      .push_slot_i (push_slot),
      .push_sel_i  (push_sel),
      .pop_i       (pop),
      .pop_slot_i  (pop_slot),
      .status_o    (slot_status[i])
    );
  end

  // ------------------------------
  // R path
  // ------------------------------
  r_merge #(
    .NUM_PORTS (NUM_PORTS)
  ) i_r_merge (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_i       (mst_r_i),
    .r_ready_i     (r_ready_i),
    .mst_r_ready_o (mst_r_ready_o),
    .r_valid_o     (r_valid_o),
    .r_o           (r_o),
    .pop_o         (pop),
    .pop_slot_o    (pop_slot)
  );

endmodule

`default_nettype wire

// File: r_merge.sv
`default_nettype none
`timescale 1ns/1ps

// merges downstream R bursts onto the upstream R channel
// lock-in round robin, grant held while a beat waits for ready
module r_merge #(
  parameter int unsigned NUM_PORTS = 3
) (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_i,
  input  wire logic [NUM_PORTS-1:0]                  mst_r_valid_i,
  input  wire axi_rd_pkg::r_chan_t [NUM_PORTS-1:0]   mst_r_i,
  input  wire logic                                  r_ready_i,
  output      logic [NUM_PORTS-1:0]                  mst_r_ready_o,
  output      logic                                  r_valid_o,
  output      axi_rd_pkg::r_chan_t                   r_o,
  output      logic                                  pop_o,
  output      demux_ctrl_pkg::look_id_t              pop_slot_o
);

  // priority pointer, doubles as the held grant while locked
  demux_ctrl_pkg::port_sel_t rr_ptr_q;
  logic                      lock_q;
  demux_ctrl_pkg::port_sel_t search_idx;
  demux_ctrl_pkg::port_sel_t gnt_idx;
  demux_ctrl_pkg::port_sel_t next_ptr;
  logic                      gnt_valid;
  logic                      r_xfer;

  // ------------------------------
  // round-robin search
  // ------------------------------

  // walk from the far end back to the pointer so the nearest valid wins
  always_comb begin : rr_search
    int unsigned cand;
    search_idx = rr_ptr_q;
    for (int off = NUM_PORTS - 1; off >= 0; off--) begin
      cand = rr_ptr_q + off;
      if (cand >= NUM_PORTS) begin
        cand = cand - NUM_PORTS;
      end
      if (mst_r_valid_i[cand]) begin
        search_idx = demux_ctrl_pkg::port_sel_t'(cand);
      end
    end
  end

  assign gnt_idx = lock_q ? rr_ptr_q : search_idx;

  // ------------------------------
  // grant mux
  // ------------------------------
  always_comb begin
    gnt_valid = 1'b0;
    r_o       = mst_r_i[0];
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      if (gnt_idx == demux_ctrl_pkg::port_sel_t'(p)) begin
        gnt_valid = mst_r_valid_i[p];
        r_o       = mst_r_i[p];
      end
    end
  end

  // only the granted port sees upstream ready
  always_comb begin
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      mst_r_ready_o[p] = r_ready_i && gnt_valid &&
                         (gnt_idx == demux_ctrl_pkg::port_sel_t'(p));
    end
  end

  assign r_valid_o = |mst_r_valid_i;
  assign r_xfer    = gnt_valid & r_ready_i;

  // last beat out means one burst fewer for that id
  assign pop_o      = r_xfer & r_o.last;
  assign pop_slot_o = r_o.id[demux_ctrl_pkg::LOOK_BITS-1:0];

  // ------------------------------
  // arbiter state
  // ------------------------------

  // port after the granted one, wrapping at NUM_PORTS
  assign next_ptr = (gnt_idx == demux_ctrl_pkg::port_sel_t'(NUM_PORTS - 1)) ?
                    '0 : gnt_idx + 1'b1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_ptr_q <= '0;
      lock_q   <= 1'b0;
    end else if (r_xfer) begin
      // served, move priority past this port
      rr_ptr_q <= next_ptr;
      lock_q   <= 1'b0;
    end else if (gnt_valid) begin
      // beat stalled, keep it granted
      rr_ptr_q <= gnt_idx;
      lock_q   <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: ar_route.sv
`default_nettype none
`timescale 1ns/1ps

// routes the upstream AR to one downstream port, fully combinational
module ar_route #(
  parameter int unsigned NUM_PORTS = 3
) (
  input  wire logic                                                  ar_valid_i,
  input  wire axi_rd_pkg::ar_chan_t                                  ar_i,
  input  wire demux_ctrl_pkg::port_sel_t                             ar_sel_i,
  input  wire logic [NUM_PORTS-1:0]                                  mst_ar_ready_i,
  input  wire demux_ctrl_pkg::slot_status_t [demux_ctrl_pkg::NUM_SLOTS-1:0] slot_status_i,
  output      logic                                                  ar_ready_o,
  output      logic [NUM_PORTS-1:0]                                  mst_ar_valid_o,
  output      axi_rd_pkg::ar_chan_t [NUM_PORTS-1:0]                  mst_ar_o,
  output      logic                                                  push_o,
  output      demux_ctrl_pkg::look_id_t                              push_slot_o,
  output      demux_ctrl_pkg::port_sel_t                             push_sel_o
);

  demux_ctrl_pkg::look_id_t     look_slot;
  demux_ctrl_pkg::slot_status_t look_status;
  logic                         any_full;
  logic                         conflict;
  logic                         fwd_valid;
  logic                         sel_ready;

  // ------------------------------
  // id lookup
  // ------------------------------

  // low id bits pick the slot
  assign look_slot   = ar_i.id[demux_ctrl_pkg::LOOK_BITS-1:0];
  assign look_status = slot_status_i[look_slot];

  // any full counter blocks the whole channel, one more push could overflow it
  always_comb begin
    any_full = 1'b0;
    for (int unsigned s = 0; s < demux_ctrl_pkg::NUM_SLOTS; s++) begin
      any_full = any_full | slot_status_i[s].full;
    end
  end

  // same id still in flight on another port
  // R beats could then come back out of order
  assign conflict = look_status.occupied && (look_status.sel != ar_sel_i);

  // stall inputs are slot state and held AR inputs only
  // pops just release a stall, so the valid never drops early
  assign fwd_valid = ar_valid_i && !any_full && !conflict;

  // ------------------------------
  // port routing
  // ------------------------------

  // ready of the addressed port, out-of-range selects read as not ready
  always_comb begin
    sel_ready = 1'b0;
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      if (ar_sel_i == demux_ctrl_pkg::port_sel_t'(p)) begin
        sel_ready = mst_ar_ready_i[p];
      end
    end
  end

  // word goes to all ports, valid only to the selected one
  always_comb begin
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      mst_ar_o[p]       = ar_i;
      mst_ar_valid_o[p] = fwd_valid && (ar_sel_i == demux_ctrl_pkg::port_sel_t'(p));
    end
  end

  assign ar_ready_o = fwd_valid & sel_ready;

  // record the burst in its slot on the transfer
  assign push_o      = ar_ready_o;
  assign push_slot_o = look_slot;
  assign push_sel_o  = ar_sel_i;

endmodule

`default_nettype wire

// File: id_slot.sv
`default_nettype none
`timescale 1ns/1ps

// outstanding read bursts for one low id value
module id_slot #(
  parameter int unsigned MAX_TRANS = 4,
  parameter int unsigned SLOT_IDX  = 0
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_i,
  input  wire logic                         push_i,
  input  wire demux_ctrl_pkg::look_id_t     push_slot_i,
  input  wire demux_ctrl_pkg::port_sel_t    push_sel_i,
  input  wire logic                         pop_i,
  input  wire demux_ctrl_pkg::look_id_t     pop_slot_i,
  output      demux_ctrl_pkg::slot_status_t status_o
);

  localparam int unsigned CNT_WIDTH = $clog2(MAX_TRANS);

  logic [CNT_WIDTH-1:0]      cnt_q;
  demux_ctrl_pkg::port_sel_t sel_q;
  logic                      push_hit;
  logic                      pop_hit;

  // strobes aimed at this slot
  assign push_hit = push_i && (push_slot_i == demux_ctrl_pkg::look_id_t'(SLOT_IDX));
  assign pop_hit  = pop_i && (pop_slot_i == demux_ctrl_pkg::look_id_t'(SLOT_IDX));

  // ------------------------------
  // burst counter
  // ------------------------------

  // push and pop together cancel
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (push_hit && !pop_hit) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (pop_hit && !push_hit) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // port of the latest burst, only read while occupied
  always_ff @(posedge clk_i) begin
    if (push_hit) begin
      sel_q <= push_sel_i;
    end
  end

  // full at MAX_TRANS-1 so the counter never wraps
  assign status_o.occupied = |cnt_q;
  assign status_o.full     = &cnt_q;
  assign status_o.sel      = sel_q;

endmodule

`default_nettype wire

// File: demux_ctrl_pkg.sv
`default_nettype none

// control types for port routing and the per-id ordering slots
package demux_ctrl_pkg;

  // ------------------------------
  // downstream port select
  // ------------------------------
  localparam int unsigned MAX_PORTS = 4;
  localparam int unsigned SEL_WIDTH = 2;

  typedef logic [SEL_WIDTH-1:0] port_sel_t;

  // ------------------------------
  // id lookup slots
  // ------------------------------

  // low id bits that pick the ordering slot
  localparam int unsigned LOOK_BITS = 2;
  localparam int unsigned NUM_SLOTS = 2 ** LOOK_BITS;

  typedef logic [LOOK_BITS-1:0] look_id_t;

  // what one slot tells the AR router
  typedef struct packed {
    logic      occupied;
    logic      full;
    port_sel_t sel;
  } slot_status_t;

endpackage

`default_nettype wire

// File: axi_rd_pkg.sv
`default_nettype none

// read-channel types shared by the demux and its testbench
package axi_rd_pkg;

  // ------------------------------
  // bus widths
  // ------------------------------

  // full transaction id, only the low bits take part in ordering
  localparam int unsigned ID_WIDTH   = 4;
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  // beats per burst minus one, as on AXI4
  localparam int unsigned LEN_WIDTH  = 8;

  typedef logic [ID_WIDTH-1:0]   id_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [LEN_WIDTH-1:0]  len_t;

  // normal access completed
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // ------------------------------
  // channel payloads
  // ------------------------------

  // read address request, size and burst type are fixed by the system
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  // one read data beat
  typedef struct packed {
    id_t        id;
    data_t      data;
    logic [1:0] resp;
    // marks the final beat of a burst
    logic       last;
  } r_chan_t;

endpackage

`default_nettype wire
